// File: free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  logic                clock,
  input  logic                reset,
  input  logic                pop,                      // Tag taken by dispatch
  input  logic                push,                     // Tag returned by commit
  input  ooo_types_pkg::tag_t push_tag,
  output ooo_types_pkg::tag_t head_tag,                 // Next tag handed out
  output logic                empty
);

  import ooo_config_pkg::*;
  import ooo_types_pkg::*;

  tag_t                   slots [free_depth];           // Circular tag storage
  logic [ptr_width-1:0]   head;                         // Oldest free tag
  logic [ptr_width-1:0]   tail;                         // Next write slot
  logic [count_width-1:0] count;                        // Tags currently held
  logic                   full;
  logic                   do_pop;
  logic                   do_push;

  assign empty    = count == '0;
  assign full     = count == count_width'(free_depth);
  assign head_tag = slots[head];                        // Shown ahead of the pop

  // Pop needs a tag, push needs room unless a pop frees a slot
  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);           // Overflow dropped

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;                                      // Wraps onto head when full
      count <= count_width'(free_depth);
      for (int i = 0; i < free_depth; i++) begin
        slots[i] <= tag_t'(num_arch_regs + i);          // Upper tags in order
      end
    end else begin
      if (do_pop) begin
        head <= head + 1'b1;                            // Pointer wraps at depth
      end
      if (do_push) begin
        slots[tail] <= push_tag;
        tail        <= tail + 1'b1;
      end
      count <= count + count_width'(do_push) - count_width'(do_pop);
    end
  end

endmodule

`default_nettype wire

// File: issue_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage_asserts (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  ooo_types_pkg::rs_entry_t [ooo_config_pkg::num_fu-1:0]   entries,
  input  ooo_types_pkg::issue_slot_t [ooo_config_pkg::num_fu-1:0] issue_slots,
  input  logic [ooo_config_pkg::num_fu-1:0]                       grant,
  input  logic                                                    rs_hazard,
  input  logic                                                    push,
  input  logic                                                    pop,
  input  logic [ooo_config_pkg::count_width-1:0]                  free_count
);

  import ooo_config_pkg::*;

  logic [num_fu-1:0] held;                              // Written and not yet issued

  // Occupancy rebuilt from dispatch grants and issues
  always_ff @(posedge clock) begin
    if (reset) begin
      held <= '0;
    end else begin
      for (int i = 0; i < num_fu; i++) begin
        if (grant[i]) begin
          held[i] <= 1'b1;                              // New occupant replaces issuer
        end else if (issue_slots[i].valid) begin
          held[i] <= 1'b0;
        end
      end
    end
  end

  // Issue only from an occupied entry
  for (genvar i = 0; i < num_fu; i++) begin : g_slot
    valid_needs_busy: assert property (@(posedge clock) disable iff (reset)
      issue_slots[i].valid |-> held[i])
      else $error("Issue valid on an empty entry %0d", i);

    // Payload untouched across a hazard cycle
    no_write_on_hazard: assert property (@(posedge clock) disable iff (reset)
      rs_hazard |=> $stable({entries[i].inst, entries[i].func, entries[i].dest_tag}))
      else $error("Entry %0d written while rs_hazard is high", i);
  end

  no_push_when_full: assert property (@(posedge clock) disable iff (reset)
    push && !pop |-> free_count != count_width'(free_depth))
    else $error("Free list push beyond capacity");

endmodule

// Station signals plus the free list occupancy next to it
bind issue_stage_top issue_stage_asserts issue_stage_asserts_inst (
  .clock       (clock),
  .reset       (reset),
  .entries     (reservation_station_inst.entries),
  .issue_slots (issue_slots),
  .grant       (reservation_station_inst.grant),
  .rs_hazard   (rs_hazard),
  .push        (release_en),
  .pop         (accept),
  .free_count  (free_list_inst.count)
);

`default_nettype wire

// File: issue_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage_top (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic                                                    dispatch_en,
  input  ooo_types_pkg::dispatch_packet_t                         dispatch_packet,
  input  ooo_types_pkg::cdb_t                                     cdb,
  input  logic                                                    release_en,
  input  ooo_types_pkg::tag_t                                     release_tag,
  output logic                                                    dispatch_stall,
  output ooo_types_pkg::issue_slot_t [ooo_config_pkg::num_fu-1:0] issue_slots,
  output ooo_types_pkg::tag_t                                     dispatch_tag
);

  import ooo_types_pkg::*;

  logic     accept;                                     // Dispatch taken this edge
  logic     rs_hazard;
  logic     free_empty;
  operand_t src1;                                       // Renamed source 1
  operand_t src2;                                       // Renamed source 2

  // Stall on a full station kind or no free tag
  assign dispatch_stall = rs_hazard || free_empty;
  assign accept         = dispatch_en && !dispatch_stall;

  free_list free_list_inst (
    .clock    (clock),
    .reset    (reset),
    .pop      (accept),
    .push     (release_en),
    .push_tag (release_tag),
    .head_tag (dispatch_tag),                           // Tag the dispatch receives
    .empty    (free_empty)
  );

  map_table map_table_inst (
    .clock     (clock),
    .reset     (reset),
    .write_en  (accept),
    .write_reg (dispatch_packet.dest_reg),
    .write_tag (dispatch_tag),
    .src1_reg  (dispatch_packet.src1_reg),
    .src2_reg  (dispatch_packet.src2_reg),
    .cdb       (cdb),
    .src1      (src1),
    .src2      (src2)
  );

  reservation_station reservation_station_inst (
    .clock         (clock),
    .reset         (reset),
    .dispatch_en   (accept),                            // Gated by the stall
    .dispatch_fu   (dispatch_packet.fu),
    .dispatch_func (dispatch_packet.func),
    .dispatch_inst (dispatch_packet.inst),
    .dispatch_tag  (dispatch_tag),
    .dispatch_t1   (src1),
    .dispatch_t2   (src2),
    .cdb           (cdb),
    .rs_hazard     (rs_hazard),
    .issue_slots   (issue_slots)
  );

endmodule

`default_nettype wire

// File: list.f
ooo_config_pkg.sv
ooo_types_pkg.sv
free_list.sv
map_table.sv
reservation_station.sv
issue_stage_top.sv
issue_stage_asserts.sv
tb_issue_stage.sv

// File: map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  write_en,  // Accepted dispatch
  input  logic [ooo_config_pkg::reg_width-1:0]  write_reg, // Arch destination
  input  ooo_types_pkg::tag_t                   write_tag, // Freshly popped tag
  input  logic [ooo_config_pkg::reg_width-1:0]  src1_reg,
  input  logic [ooo_config_pkg::reg_width-1:0]  src2_reg,
  input  ooo_types_pkg::cdb_t                   cdb,
  output ooo_types_pkg::operand_t               src1,
  output ooo_types_pkg::operand_t               src2
);

  import ooo_config_pkg::*;
  import ooo_types_pkg::*;

  operand_t map [num_arch_regs];                        // Current rename of each reg

  // Lookup with same-cycle completion bypass
  function automatic operand_t read_operand(input logic [reg_width-1:0] arch_reg);
    operand_t entry;
    entry = map[arch_reg];
    if (cdb.valid && cdb.tag == entry.tag) begin
      entry.ready = 1'b1;                               // Completing right now
    end
    return entry;
  endfunction

  always_comb begin
    src1 = read_operand(src1_reg);
    src2 = read_operand(src2_reg);
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < num_arch_regs; i++) begin
      if (reset) begin
        map[i].tag   <= tag_t'(i);                      // Identity mapping
        map[i].ready <= 1'b1;
      end else if (write_en && write_reg == reg_width'(i)) begin
        map[i].tag   <= write_tag;                      // New producer wins over cdb
        map[i].ready <= 1'b0;
      end else if (cdb.valid && cdb.tag == map[i].tag) begin
        map[i].ready <= 1'b1;                           // Producer finished
      end
    end
  end

endmodule

`default_nettype wire

// File: ooo_config_pkg.sv
`default_nettype none

package ooo_config_pkg;

  // Register file and tag space
  localparam int num_arch_regs = 32;                     // Architectural registers
  localparam int num_tags      = 64;                     // Physical tags
  localparam int tag_width     = 6;                      // log2(num_tags)
  localparam int reg_width     = 5;                      // log2(num_arch_regs)
  localparam int inst_width    = 32;                     // Raw instruction word

  // Free list sizing, upper tags only
  localparam int free_depth    = num_tags - num_arch_regs; // Tags not mapped at reset
  localparam int ptr_width     = 5;                        // log2(free_depth)
  localparam int count_width   = ptr_width + 1;            // Holds 0 to free_depth

  // One reservation station entry per unit
  localparam int num_fu        = 5;

  typedef enum logic [1:0] {
    fu_alu,                                              // Integer ALU
    fu_mult,                                             // Multiplier
    fu_mem,                                              // Load/store
    fu_branch                                            // Branch unit
  } fu_kind_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,                                             // Shift left
    alu_srl,                                             // Shift right
    alu_cmp                                              // Compare
  } alu_func_e;

  // Unit kind of each entry, index 0 first
  localparam fu_kind_e fu_list [num_fu] = '{fu_alu, fu_alu, fu_mult, fu_mem, fu_branch};

endpackage

`default_nettype wire

// File: ooo_types_pkg.sv
`default_nettype none

package ooo_types_pkg;

  import ooo_config_pkg::*;

  typedef logic [tag_width-1:0] tag_t;                   // Physical register tag

  // Source operand as seen by the station
  typedef struct packed {
    tag_t tag;                                           // Producer tag
    logic ready;                                         // Value available
  } operand_t;

  // Instruction offered by the front end
  typedef struct packed {
    logic [inst_width-1:0] inst;                         // Raw encoding
    fu_kind_e              fu;                           // Target unit kind
    alu_func_e             func;                         // Opcode
    logic [reg_width-1:0]  dest_reg;                     // Arch destination
    logic [reg_width-1:0]  src1_reg;                     // Arch source 1
    logic [reg_width-1:0]  src2_reg;                     // Arch source 2
  } dispatch_packet_t;

  // Completion broadcast from the units
  typedef struct packed {
    logic valid;
    tag_t tag;                                           // Tag now complete
  } cdb_t;

  // Stored reservation station entry
  typedef struct packed {
    logic                  busy;                         // Holds an instruction
    logic [inst_width-1:0] inst;
    alu_func_e             func;
    tag_t                  dest_tag;                     // Renamed destination
    operand_t              t1;
    operand_t              t2;
  } rs_entry_t;

  // Issue port toward one functional unit
  typedef struct packed {
    logic                  valid;                        // Issued this cycle
    tag_t                  dest_tag;
    tag_t                  t1_tag;
    tag_t                  t2_tag;
    alu_func_e             func;
    logic [inst_width-1:0] inst;
  } issue_slot_t;

endpackage

`default_nettype wire

// File: reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic                                                    dispatch_en,
  input  ooo_config_pkg::fu_kind_e                                dispatch_fu,
  input  ooo_config_pkg::alu_func_e                               dispatch_func,
  input  logic [ooo_config_pkg::inst_width-1:0]                   dispatch_inst,
  input  ooo_types_pkg::tag_t                                     dispatch_tag,
  input  ooo_types_pkg::operand_t                                 dispatch_t1,
  input  ooo_types_pkg::operand_t                                 dispatch_t2,
  input  ooo_types_pkg::cdb_t                                     cdb,
  output logic                                                    rs_hazard,
  output ooo_types_pkg::issue_slot_t [ooo_config_pkg::num_fu-1:0] issue_slots
);

  import ooo_config_pkg::*;
  import ooo_types_pkg::*;

  rs_entry_t [num_fu-1:0] entries;                      // One entry per unit
  rs_entry_t [num_fu-1:0] next_entries;
  logic      [num_fu-1:0] t1_hit;                       // Source 1 on cdb now
  logic      [num_fu-1:0] t2_hit;                       // Source 2 on cdb now
  logic      [num_fu-1:0] issue_ready;                  // Both sources ready
  logic      [num_fu-1:0] entry_match;                  // Free and right kind
  logic      [num_fu-1:0] grant;                        // One-hot dispatch target

  // Wakeup and issue, each source only against its own tag
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      t1_hit[i]      = cdb.valid && cdb.tag == entries[i].t1.tag;
      t2_hit[i]      = cdb.valid && cdb.tag == entries[i].t2.tag;
      issue_ready[i] = entries[i].busy
                       && (entries[i].t1.ready || t1_hit[i])
                       && (entries[i].t2.ready || t2_hit[i]);
      // Issuing entry counts as free this cycle
      entry_match[i] = (!entries[i].busy || issue_ready[i]) && fu_list[i] == dispatch_fu;
    end
  end

  assign rs_hazard = ~|entry_match;                     // No slot for this kind

  // Lowest-numbered matching entry takes the dispatch
  always_comb begin
    logic found;
    found = 1'b0;
    grant = '0;
    for (int i = 0; i < num_fu; i++) begin
      if (entry_match[i] && !found) begin
        grant[i] = dispatch_en;
        found    = 1'b1;
      end
    end
  end

  // Issue slots read straight from the entries
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      issue_slots[i].valid    = issue_ready[i];
      issue_slots[i].dest_tag = entries[i].dest_tag;
      issue_slots[i].t1_tag   = entries[i].t1.tag;
      issue_slots[i].t2_tag   = entries[i].t2.tag;
      issue_slots[i].func     = entries[i].func;
      issue_slots[i].inst     = entries[i].inst;
    end
  end

  // Next state, wakeup then issue then dispatch
  always_comb begin
    next_entries = entries;
    for (int i = 0; i < num_fu; i++) begin
      if (t1_hit[i]) begin
        next_entries[i].t1.ready = 1'b1;
      end
      if (t2_hit[i]) begin
        next_entries[i].t2.ready = 1'b1;
      end
      if (issue_ready[i]) begin
        next_entries[i].busy = 1'b0;                    // Leaves toward the unit
      end
      if (grant[i]) begin
        next_entries[i].busy     = 1'b1;
        next_entries[i].inst     = dispatch_inst;
        next_entries[i].func     = dispatch_func;
        next_entries[i].dest_tag = dispatch_tag;
        next_entries[i].t1       = dispatch_t1;         // Already bypassed upstream
        next_entries[i].t2       = dispatch_t2;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_fu; i++) begin
        entries[i].busy <= 1'b0;                        // Payload left as is
      end
    end else begin
      entries <= next_entries;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_issue_stage -o sim_issue_stage &&
{ ./obj_dir/sim_issue_stage 2>&1 | tee sim.log; } &&
grep -q -F "** PASS **" sim.log &&
! grep -q -F "** FAIL **" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;

  import ooo_config_pkg::*;
  import ooo_types_pkg::*;

  logic                    clock;
  logic                    reset;
  logic                    dispatch_en;
  dispatch_packet_t        dispatch_packet;
  cdb_t                    cdb;
  logic                    release_en;
  tag_t                    release_tag;
  logic                    dispatch_stall;
  issue_slot_t [num_fu-1:0] issue_slots;
  tag_t                    dispatch_tag;

  logic [31:0] lfsr;                                    // Stimulus LFSR state
  logic        tag_ready [num_tags];                    // Model ready bit per tag
  tag_t        reg_map [num_arch_regs];                 // Model rename map
  tag_t        free_q [$];                              // Mirror of the free list

  issue_stage_top issue_stage_top_inst (
    .clock           (clock),
    .reset           (reset),
    .dispatch_en     (dispatch_en),
    .dispatch_packet (dispatch_packet),
    .cdb             (cdb),
    .release_en      (release_en),
    .release_tag     (release_tag),
    .dispatch_stall  (dispatch_stall),
    .issue_slots     (issue_slots),
    .dispatch_tag    (dispatch_tag)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                          // 4 ns period
  end

  function automatic void stop_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Run stopped at first error");
  endfunction

  function automatic void check(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp));
    end
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Random register, optionally one whose current tag is ready
  function automatic logic [4:0] pick_reg(input logic need_ready, input int ex1, input int ex2);
    logic [31:0] bits;
    logic [4:0]  r;
    for (int tries = 0; tries < 500; tries++) begin
      bits = next_bits(5);
      r    = bits[4:0];
      if ((!need_ready || tag_ready[reg_map[r]]) && int'(r) != ex1 && int'(r) != ex2) begin
        return r;
      end
    end
    stop_run("No usable register could be picked for the next instruction");
    return 5'd0;
  endfunction

  function automatic dispatch_packet_t make_packet(input fu_kind_e fu, input logic [4:0] d,
                                                   input logic [4:0] s1, input logic [4:0] s2);
    dispatch_packet_t p;
    logic [31:0]      fn;
    fn         = next_bits(3);
    p.inst     = next_bits(32);
    p.fu       = fu;
    p.func     = alu_func_e'(fn[2:0]);
    p.dest_reg = d;
    p.src1_reg = s1;
    p.src2_reg = s2;
    return p;
  endfunction

  // Model side of an accepted dispatch
  function automatic tag_t rename(input logic [4:0] d);
    tag_t tag;
    tag            = free_q.pop_front();
    reg_map[d]     = tag;
    tag_ready[tag] = 1'b0;
    return tag;
  endfunction

  task automatic do_dispatch(input fu_kind_e fu, input logic [4:0] d, input logic [4:0] s1,
                             input logic [4:0] s2, output tag_t tag);
    int waited;
    waited = 0;
    @(posedge clock);
    dispatch_en     <= 1'b1;
    dispatch_packet <= make_packet(fu, d, s1, s2);
    @(negedge clock);
    while (dispatch_stall) begin
      if (waited >= 20) begin
        stop_run("Timeout: dispatch stayed stalled for 20 cycles");
      end
      waited++;
      @(negedge clock);
    end
    check("dispatch tag", dispatch_tag, free_q[0]);
    @(posedge clock);                                   // Accepting edge
    dispatch_en <= 1'b0;
    tag = rename(d);
  endtask

  task automatic complete(input tag_t tag);
    @(posedge clock);
    cdb <= '{valid: 1'b1, tag: tag};
    @(posedge clock);
    cdb <= '0;
    tag_ready[tag] = 1'b1;
  endtask

  task automatic test_reset_issue();
    logic [4:0] d, s1, s2;
    tag_t       t;
    @(negedge clock);
    check("stall after reset", dispatch_stall, 0);
    check("first tag", dispatch_tag, 32);              // Lowest upper tag heads the list
    for (int i = 0; i < num_fu; i++) begin
      check("valid after reset", issue_slots[i].valid, 0);
    end
    d  = pick_reg(0, -1, -1);
    s1 = pick_reg(1, -1, -1);
    s2 = pick_reg(1, -1, -1);
    do_dispatch(fu_alu, d, s1, s2, t);
    @(negedge clock);
    check("alu0 issues", issue_slots[0].valid, 1);
    check("alu0 t1", issue_slots[0].t1_tag, s1);        // Identity map after reset
    check("alu0 t2", issue_slots[0].t2_tag, s2);
    check("alu0 dest", issue_slots[0].dest_tag, t);
    check("alu0 func", issue_slots[0].func, dispatch_packet.func);
    check("alu0 inst", issue_slots[0].inst, dispatch_packet.inst);
    @(negedge clock);
    check("alu0 one cycle", issue_slots[0].valid, 0);
  endtask

  task automatic test_dependency_wait();
    logic [4:0] dp, c2, dc;
    tag_t       tp, tc, e2;
    dp = pick_reg(0, -1, -1);
    do_dispatch(fu_alu, dp, pick_reg(1, -1, -1), pick_reg(1, -1, -1), tp);
    c2 = pick_reg(1, dp, -1);
    dc = pick_reg(0, dp, c2);
    e2 = reg_map[c2];
    do_dispatch(fu_mult, dc, dp, c2, tc);
    repeat (3) begin
      @(negedge clock);
      check("mult waits", issue_slots[2].valid, 0);
    end
    @(posedge clock);
    cdb <= '{valid: 1'b1, tag: tp};
    @(negedge clock);
    check("mult wakes with cdb", issue_slots[2].valid, 1);
    check("mult t1", issue_slots[2].t1_tag, tp);
    check("mult t2", issue_slots[2].t2_tag, e2);
    check("mult dest", issue_slots[2].dest_tag, tc);
    @(posedge clock);
    cdb <= '0;
    tag_ready[tp] = 1'b1;
    @(negedge clock);
    check("mult one cycle", issue_slots[2].valid, 0);
  endtask

  task automatic test_own_tag_wakeup();
    logic [4:0] da, db;
    tag_t       ta, tb, tm;
    da = pick_reg(0, -1, -1);
    do_dispatch(fu_alu, da, pick_reg(1, -1, -1), pick_reg(1, -1, -1), ta);
    db = pick_reg(0, da, -1);
    do_dispatch(fu_alu, db, pick_reg(1, -1, -1), pick_reg(1, -1, -1), tb);
    do_dispatch(fu_mem, pick_reg(0, da, db), da, db, tm);
    @(posedge clock);
    cdb <= '{valid: 1'b1, tag: ta};                     // Matches source 1 only
    @(negedge clock);
    check("mem no issue on t1 only", issue_slots[3].valid, 0);
    @(posedge clock);
    cdb <= '0;
    tag_ready[ta] = 1'b1;
    @(negedge clock);
    check("mem still waits", issue_slots[3].valid, 0);
    @(posedge clock);
    cdb <= '{valid: 1'b1, tag: tb};
    @(negedge clock);
    check("mem issues on t2", issue_slots[3].valid, 1);
    check("mem t2", issue_slots[3].t2_tag, tb);
    check("mem dest", issue_slots[3].dest_tag, tm);
    @(posedge clock);
    cdb <= '0;
    tag_ready[tb] = 1'b1;
  endtask

  task automatic test_same_cycle_bypass();
    logic [4:0] dp, s2, d;
    tag_t       tp, tn;
    dp = pick_reg(0, -1, -1);
    do_dispatch(fu_alu, dp, pick_reg(1, -1, -1), pick_reg(1, -1, -1), tp);
    s2 = pick_reg(1, dp, -1);
    d  = pick_reg(0, dp, s2);
    @(posedge clock);
    dispatch_en     <= 1'b1;
    dispatch_packet <= make_packet(fu_branch, d, dp, s2);
    cdb             <= '{valid: 1'b1, tag: tp};         // Completes while being read
    @(negedge clock);
    check("bypass no stall", dispatch_stall, 0);
    check("bypass tag", dispatch_tag, free_q[0]);
    @(posedge clock);
    dispatch_en <= 1'b0;
    cdb         <= '0;
    tag_ready[tp] = 1'b1;
    tn = rename(d);
    @(negedge clock);
    check("branch issues next cycle", issue_slots[4].valid, 1);
    check("branch t1", issue_slots[4].t1_tag, tp);
    check("branch dest", issue_slots[4].dest_tag, tn);
  endtask

  task automatic test_alu_full_stall();
    logic [4:0] rx, ry, dc;
    tag_t       tx, ty, t;
    rx = pick_reg(0, -1, -1);
    do_dispatch(fu_mult, rx, pick_reg(1, -1, -1), pick_reg(1, -1, -1), tx);
    ry = pick_reg(0, rx, -1);
    do_dispatch(fu_branch, ry, pick_reg(1, -1, -1), pick_reg(1, -1, -1), ty);
    do_dispatch(fu_alu, pick_reg(0, rx, ry), rx, pick_reg(1, -1, -1), t);
    do_dispatch(fu_alu, pick_reg(0, rx, ry), ry, pick_reg(1, -1, -1), t);
    dc = pick_reg(0, rx, ry);
    @(posedge clock);
    dispatch_en     <= 1'b1;
    dispatch_packet <= make_packet(fu_alu, dc, pick_reg(1, -1, -1), pick_reg(1, -1, -1));
    @(negedge clock);
    check("third alu stalls", dispatch_stall, 1);
    @(negedge clock);
    check("third alu still stalls", dispatch_stall, 1);
    @(posedge clock);
    cdb <= '{valid: 1'b1, tag: tx};                     // Entry 0 issues now
    @(negedge clock);
    check("stall clears on issue", dispatch_stall, 0);
    check("alu0 issues", issue_slots[0].valid, 1);
    check("third alu tag", dispatch_tag, free_q[0]);
    @(posedge clock);
    dispatch_en <= 1'b0;
    cdb         <= '0;
    tag_ready[tx] = 1'b1;
    t = rename(dc);
    @(negedge clock);
    check("third alu issues", issue_slots[0].valid, 1);
    check("third alu dest", issue_slots[0].dest_tag, t);
    check("alu1 still waits", issue_slots[1].valid, 0);
    complete(ty);
  endtask

  task automatic test_free_list_empty();
    logic [4:0] d;
    tag_t       t;
    while (free_q.size() > 0) begin
      do_dispatch(fu_alu, pick_reg(0, -1, -1), pick_reg(1, -1, -1), pick_reg(1, -1, -1), t);
      complete(t);
    end
    d = pick_reg(0, -1, -1);
    @(posedge clock);
    dispatch_en     <= 1'b1;
    dispatch_packet <= make_packet(fu_alu, d, pick_reg(1, -1, -1), pick_reg(1, -1, -1));
    @(negedge clock);
    check("stall on empty list", dispatch_stall, 1);
    @(posedge clock);
    release_en  <= 1'b1;
    release_tag <= 6'd32;
    @(negedge clock);
    check("stall before push lands", dispatch_stall, 1);
    @(posedge clock);
    release_en <= 1'b0;
    free_q.push_back(6'd32);
    @(negedge clock);
    check("stall clears after release", dispatch_stall, 0);
    check("released tag reused", dispatch_tag, 32);
    @(posedge clock);
    t = rename(d);
    @(negedge clock);
    check("only one dispatch passes", dispatch_stall, 1);
    @(posedge clock);
    dispatch_en <= 1'b0;
  endtask

  initial begin
    lfsr            = 32'hf42c8b29;
    reset           = 1'b1;
    dispatch_en     = 1'b0;
    dispatch_packet = '0;
    cdb             = '0;
    release_en      = 1'b0;
    release_tag     = '0;
    for (int i = 0; i < num_tags; i++) begin
      tag_ready[i] = i < num_arch_regs;                 // Mapped tags start ready
    end
    for (int i = 0; i < num_arch_regs; i++) begin
      reg_map[i] = tag_t'(i);
      free_q.push_back(tag_t'(num_arch_regs + i));
    end
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    test_reset_issue();
    test_dependency_wait();
    test_own_tag_wakeup();
    test_same_cycle_bypass();
    test_alu_full_stall();
    test_free_list_empty();
    repeat (2) @(posedge clock);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
